//--- rtl/dcache_pkg.sv
package dcache_pkg;

        // ------------------------------
        // Cache geometry.
        // ------------------------------
        localparam int LINE_BYTES  = 16;        // Bytes per line.
        localparam int LINE_WORDS  = 4;         // Words per line.
        localparam int CACHE_LINES = 16;        // 256 bytes in all.
        localparam int INDEX_W     = 4;         // Line index width.
        localparam int TAG_W       = 24;        // Tag width.

        // ------------------------------
        // Address fields.
        // ------------------------------
        // Offset is 3:0, word select 3:2.
        localparam int INDEX_LSB   = 4;         // Index is 7:4.
        localparam int TAG_LSB     = 8;         // Tag is 31:8.

        // One line, seen as words by the fill and the
        // load path, and as bytes by the store writes.
        typedef union packed {
                logic [LINE_WORDS-1:0][31:0] words;
                logic [LINE_BYTES-1:0][7:0]  bytes;
        } line_t;

        // Controller states.
        typedef enum logic [2:0] {
                IDLE    = 3'd0,
                FILL_0  = 3'd1,
                FILL_1  = 3'd2,
                FILL_2  = 3'd3,
                FILL_3  = 3'd4,
                REFRESH = 3'd5
        } fill_state_t;

endpackage

//--- rtl/line_fill_fsm.sv
`timescale 1ns/1ps

module line_fill_fsm
        import dcache_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_clear_from_writeback, // Highest priority.
        input  logic        i_cache_en,
        input  logic        i_read_en,
        input  logic        i_write_en,
        input  logic [3:0]  i_ben,
        input  logic [31:0] i_wr_data,
        input  logic [31:0] i_address,
        input  logic        i_hit,
        input  logic [31:0] i_ram_rd_data,
        input  logic        i_ram_done,
        output logic        o_stall,                // Combinational.
        output logic        o_bypass,
        output logic [31:0] o_ram_address,
        output logic [31:0] o_ram_wr_data,
        output logic [3:0]  o_ram_ben,
        output logic        o_ram_rd_en,
        output logic        o_ram_wr_en,
        output logic        o_line_wen,
        output logic [15:0] o_line_ben,
        output line_t       o_line_wdata,
        output logic        o_tag_wen,
        output logic        o_refresh
);

        fill_state_t state, state_nxt;
        line_t       fill_buf;          // First three fill words.
        logic        buf_wen;
        logic [1:0]  fill_word;         // Word being fetched.

        // ------------------------------
        // Next state and outputs.
        // ------------------------------
        always_comb
        begin
                state_nxt     = state;
                o_stall       = 1'b0;
                o_bypass      = 1'b0;
                o_ram_address = i_address;
                o_ram_wr_data = i_wr_data;      // RAM writes are always CPU data.
                o_ram_ben     = i_ben;
                o_ram_rd_en   = 1'b0;
                o_ram_wr_en   = 1'b0;
                o_line_wen    = 1'b0;
                o_line_ben    = '0;
                o_tag_wen     = 1'b0;
                o_refresh     = 1'b0;
                buf_wen       = 1'b0;
                fill_word     = 2'(state - FILL_0);

                // Write data copied to every word; the byte mask picks one.
                o_line_wdata.words = {LINE_WORDS{i_wr_data}};

                case (state)
                IDLE:
                begin
                        if (!i_cache_en)
                        begin
                                // Pass-through to RAM.
                                o_bypass    = 1'b1;
                                o_ram_rd_en = i_read_en;
                                o_ram_wr_en = i_write_en;
                                o_stall     = (i_read_en || i_write_en) && !i_ram_done;
                        end
                        else if (i_write_en)
                        begin
                                o_ram_wr_en = 1'b1;     // Write-through.
                                o_stall     = !i_ram_done;

                                // Merge on hit as RAM completes.
                                if (i_ram_done && i_hit)
                                begin
                                        o_line_wen = 1'b1;
                                        o_line_ben = {12'd0, i_ben} << {i_address[3:2], 2'b00};
                                end
                        end
                        else if (i_read_en && !i_hit)
                        begin
                                o_stall   = 1'b1;       // Miss. Start linefill.
                                state_nxt = FILL_0;
                        end
                end

                FILL_0, FILL_1, FILL_2, FILL_3:
                begin
                        o_stall       = 1'b1;
                        o_ram_rd_en   = 1'b1;
                        o_ram_ben     = 4'hF;
                        o_ram_address = {i_address[31:INDEX_LSB], fill_word, 2'b00};

                        if (i_ram_done)
                        begin
                                if (state == FILL_3)
                                begin
                                        // Last word completes the line.
                                        o_line_wdata           = fill_buf;
                                        o_line_wdata.words[3]  = i_ram_rd_data;
                                        o_line_ben             = '1;
                                        o_line_wen             = 1'b1;
                                        o_tag_wen              = 1'b1;
                                        state_nxt              = REFRESH;
                                end
                                else
                                begin
                                        buf_wen   = 1'b1;
                                        state_nxt = fill_state_t'(state + 3'd1);
                                end
                        end
                end

                REFRESH:
                begin
                        o_stall   = 1'b1;
                        o_refresh = 1'b1;       // Re-read the new line.
                        state_nxt = IDLE;
                end

                default:
                begin
                        state_nxt = IDLE;
                end
                endcase
        end

        // ------------------------------
        // Registers.
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear_from_writeback)
                        state <= IDLE;
                else
                        state <= state_nxt;
        end

        // Fill buffer.
        always_ff @(posedge i_clk)
        begin
                if (buf_wen)
                        fill_buf.words[fill_word] <= i_ram_rd_data;
        end

endmodule

//--- rtl/line_store.sv
`timescale 1ns/1ps

module line_store
        import dcache_pkg::*;
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_cache_en,
        input  logic               i_cache_inv,
        input  logic               i_stall,
        input  logic               i_refresh,
        input  logic [INDEX_W-1:0] i_rd_index,      // Next access.
        input  logic [INDEX_W-1:0] i_cur_index,     // Current access, write index.
        input  logic               i_tag_wen,
        input  logic [TAG_W-1:0]   i_wr_tag,
        input  logic               i_line_wen,
        input  logic [15:0]        i_line_ben,
        input  line_t              i_line_wdata,
        output logic [TAG_W-1:0]   o_tag,
        output logic               o_valid,
        output line_t              o_line
);

        logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
        line_t                  line_mem [CACHE_LINES];
        logic [CACHE_LINES-1:0] valid;

        logic [INDEX_W-1:0]     rd_idx;
        logic                   rd_en;
        logic                   inv;
        line_t                  fwd_line;       // Read data with same-edge write.

        assign inv    = i_reset || i_cache_inv || !i_cache_en;
        assign rd_en  = i_refresh || !i_stall;
        assign rd_idx = i_refresh ? i_cur_index : i_rd_index;

        // Bytes written at the read edge pass straight through.
        always_comb
        begin
                fwd_line = line_mem[rd_idx];
                if (i_line_wen && rd_idx == i_cur_index)
                begin
                        for (int b = 0; b < LINE_BYTES; b++)
                        begin
                                if (i_line_ben[b])
                                        fwd_line.bytes[b] = i_line_wdata.bytes[b];
                        end
                end
        end

        // ------------------------------
        // Writes.
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_tag_wen)
                        tag_mem[i_cur_index] <= i_wr_tag;
                for (int b = 0; b < LINE_BYTES; b++)
                begin
                        if (i_line_wen && i_line_ben[b])
                                line_mem[i_cur_index].bytes[b] <= i_line_wdata.bytes[b];
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (inv)
                        valid <= '0;                    // Flush all lines.
                else if (i_tag_wen)
                        valid[i_cur_index] <= 1'b1;
        end

        // ------------------------------
        // Registered reads.
        // ------------------------------
        always_ff @(posedge i_clk)
        begin
                if (inv)
                        o_valid <= 1'b0;
                else if (rd_en)
                        o_valid <= valid[rd_idx];
        end

        always_ff @(posedge i_clk)
        begin
                if (rd_en)
                begin
                        o_tag  <= tag_mem[rd_idx];
                        o_line <= fwd_line;
                end
        end

endmodule

//--- rtl/load_return.sv
`timescale 1ns/1ps

module load_return
        import dcache_pkg::*;
(
        input  logic [31:0]      i_address,
        input  logic             i_bypass,         // Cache off.
        input  logic [TAG_W-1:0] i_tag,
        input  logic             i_valid,
        input  line_t            i_line,
        input  logic [31:0]      i_ram_rd_data,
        output logic             o_hit,
        output logic [31:0]      o_rd_data
);

        // Hit on a valid line with a matching tag.
        assign o_hit = i_valid && (i_tag == i_address[31:TAG_LSB]);

        // Word select from offset bits 3:2.
        always_comb
        begin
                if (i_bypass)
                        o_rd_data = i_ram_rd_data;
                else
                        o_rd_data = i_line.words[i_address[3:2]];
        end

endmodule

//--- rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
        import dcache_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        // CPU request.
        input  logic        i_read_en,
        input  logic        i_write_en,
        input  logic [3:0]  i_ben,
        input  logic [31:0] i_wr_data,
        input  logic [31:0] i_address,
        input  logic [31:0] i_address_nxt,
        // CPU response.
        output logic [31:0] o_rd_data,
        output logic        o_stall,
        // Control.
        input  logic        i_cache_en,
        input  logic        i_cache_inv,
        input  logic        i_clear_from_writeback,
        // RAM port.
        output logic [31:0] o_ram_address,
        output logic [31:0] o_ram_wr_data,
        output logic [3:0]  o_ram_ben,
        output logic        o_ram_rd_en,
        output logic        o_ram_wr_en,
        input  logic [31:0] i_ram_rd_data,
        input  logic        i_ram_done
);

        // ------------------------------
        // Internal nets.
        // ------------------------------
        logic               hit;        // Tag match and valid.
        logic               bypass;     // Cache off, RAM data out.
        logic               line_wen;
        logic [15:0]        line_ben;
        line_t              line_wdata;
        logic               tag_wen;
        logic               refresh;    // Re-read pulse after a fill.
        logic [TAG_W-1:0]   tag;
        logic               valid;
        line_t              line;

        line_fill_fsm u_fsm (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_cache_en             (i_cache_en),
                .i_read_en              (i_read_en),
                .i_write_en             (i_write_en),
                .i_ben                  (i_ben),
                .i_wr_data              (i_wr_data),
                .i_address              (i_address),
                .i_hit                  (hit),
                .i_ram_rd_data          (i_ram_rd_data),
                .i_ram_done             (i_ram_done),
                .o_stall                (o_stall),
                .o_bypass               (bypass),
                .o_ram_address          (o_ram_address),
                .o_ram_wr_data          (o_ram_wr_data),
                .o_ram_ben              (o_ram_ben),
                .o_ram_rd_en            (o_ram_rd_en),
                .o_ram_wr_en            (o_ram_wr_en),
                .o_line_wen             (line_wen),
                .o_line_ben             (line_ben),
                .o_line_wdata           (line_wdata),
                .o_tag_wen              (tag_wen),
                .o_refresh              (refresh)
        );

        // Next index is looked up while the current access completes.
        line_store u_store (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_cache_en     (i_cache_en),
                .i_cache_inv    (i_cache_inv),
                .i_stall        (o_stall),
                .i_refresh      (refresh),
                .i_rd_index     (i_address_nxt[TAG_LSB-1:INDEX_LSB]),
                .i_cur_index    (i_address[TAG_LSB-1:INDEX_LSB]),
                .i_tag_wen      (tag_wen),
                .i_wr_tag       (i_address[31:TAG_LSB]),
                .i_line_wen     (line_wen),
                .i_line_ben     (line_ben),
                .i_line_wdata   (line_wdata),
                .o_tag          (tag),
                .o_valid        (valid),
                .o_line         (line)
        );

        load_return u_ret (
                .i_address      (i_address),
                .i_bypass       (bypass),
                .i_tag          (tag),
                .i_valid        (valid),
                .i_line         (line),
                .i_ram_rd_data  (i_ram_rd_data),
                .o_hit          (hit),
                .o_rd_data      (o_rd_data)
        );

endmodule

//--- verification/dcache_tests.svh
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

// ------------------------------
// CPU side.
// ------------------------------
// One access. Entered just after a rising edge.
task automatic cpu_access(input logic is_wr, input logic [31:0] addr, input logic [3:0] ben,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int stalls);
        i_read_en     = 1'b0;
        i_write_en    = 1'b0;
        i_address_nxt = addr;                   // Idle cycle lets the store look it up.
        @(posedge i_clk);
        #STIM_DELAY;
        i_address  = addr;
        i_read_en  = !is_wr;
        i_write_en = is_wr;
        i_ben      = ben;
        i_wr_data  = wdata;
        stalls     = 0;
        @(negedge i_clk);
        while (o_stall)
        begin
                stalls++;
                @(negedge i_clk);
        end
        rdata = o_rd_data;                      // Done cycle. Output is settled.
        @(posedge i_clk);
        #STIM_DELAY;
        i_read_en  = 1'b0;
        i_write_en = 1'b0;
endtask

task automatic pulse_invalidate();
        i_cache_inv = 1'b1;
        @(posedge i_clk);
        #STIM_DELAY;
        i_cache_inv = 1'b0;
endtask

task automatic clear_ram_log();
        rd_log.delete();
        wr_log.delete();
endtask

// Four word reads from the line base.
task automatic check_fill_reads(input logic [31:0] base);
        check_value("ram read count", 32'(rd_log.size()), 32'd4);
        for (int i = 0; i < 4 && i < rd_log.size(); i++)
                check_value("o_ram_address", rd_log[i], base + 32'(4 * i));
endtask

// One RAM access, of the same kind as the CPU access.
task automatic check_single_access(input logic is_wr, input logic [31:0] addr);
        check_value("ram read count", 32'(rd_log.size()), is_wr ? 32'd0 : 32'd1);
        check_value("ram write count", 32'(wr_log.size()), is_wr ? 32'd1 : 32'd0);
        if (is_wr && wr_log.size() == 1)
                check_value("o_ram_address", wr_log[0], addr);
        else if (!is_wr && rd_log.size() == 1)
                check_value("o_ram_address", rd_log[0], addr);
endtask

// ------------------------------
// Directed tests.
// ------------------------------
task automatic read_miss_fill();
        logic [31:0] rdata;
        int          stalls;
        clear_ram_log();
        cpu_access(1'b0, 32'h0000_0124, 4'hF, '0, rdata, stalls);   // Cold line.
        check_value("o_rd_data", rdata, pattern_word(32'h0000_0124));
        check_fill_reads(32'h0000_0120);
endtask

task automatic read_hit_all_words();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          stalls;
        clear_ram_log();
        for (int w = 0; w < 4; w++)
        begin
                addr = 32'h0000_0120 + 32'(4 * w);
                cpu_access(1'b0, addr, 4'hF, '0, rdata, stalls);
                check_value("o_rd_data", rdata, ram_mem[addr[13:2]]);
                check_value("o_stall cycles", 32'(stalls), 32'd0);  // Hit, no wait.
        end
        check_value("ram read count", 32'(rd_log.size()), 32'd0);
endtask

task automatic write_through_merge();
        logic [31:0] addr;
        logic [31:0] expected;
        logic [31:0] rdata;
        int          stalls;
        addr     = 32'h0000_0128;
        expected = merge_bytes(ram_mem[addr[13:2]], 32'hDEAD_BEEF, 4'b0110);
        clear_ram_log();
        cpu_access(1'b1, addr, 4'b0110, 32'hDEAD_BEEF, rdata, stalls);
        check_single_access(1'b1, addr);
        check_value("ram word", ram_mem[addr[13:2]], expected);
        cpu_access(1'b0, addr, 4'hF, '0, rdata, stalls);           // Merged copy in cache.
        check_value("o_rd_data", rdata, expected);
        check_value("o_stall cycles", 32'(stalls), 32'd0);
        check_value("ram read count", 32'(rd_log.size()), 32'd0);
endtask

task automatic invalidate_and_refill();
        logic [31:0] rdata;
        int          stalls;
        pulse_invalidate();
        clear_ram_log();
        cpu_access(1'b0, 32'h0000_0124, 4'hF, '0, rdata, stalls);
        check_value("o_rd_data", rdata, ram_mem[12'h049]);
        check_fill_reads(32'h0000_0120);
endtask

// Same index 3, tags 0x000002 and 0x000022.
task automatic conflict_replacement();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          stalls;
        for (int n = 0; n < 4; n++)
        begin
                addr = (n % 2 == 0) ? 32'h0000_0234 : 32'h0000_2238;
                clear_ram_log();
                cpu_access(1'b0, addr, 4'hF, '0, rdata, stalls);
                check_value("o_rd_data", rdata, ram_mem[addr[13:2]]);
                check_fill_reads({addr[31:4], 4'h0});
        end
endtask

task automatic cache_disabled_passthrough();
        logic [31:0] expected;
        logic [31:0] rdata;
        int          stalls;
        i_cache_en = 1'b0;
        @(posedge i_clk);
        #STIM_DELAY;
        clear_ram_log();
        cpu_access(1'b0, 32'h0000_0300, 4'hF, '0, rdata, stalls);
        check_single_access(1'b0, 32'h0000_0300);
        check_value("o_rd_data", rdata, ram_mem[12'h0C0]);
        expected = merge_bytes(ram_mem[12'h0C1], 32'h1122_3344, 4'b1001);
        clear_ram_log();
        cpu_access(1'b1, 32'h0000_0304, 4'b1001, 32'h1122_3344, rdata, stalls);
        check_single_access(1'b1, 32'h0000_0304);
        check_value("ram word", ram_mem[12'h0C1], expected);
        clear_ram_log();
        cpu_access(1'b0, 32'h0000_0304, 4'hF, '0, rdata, stalls);  // Straight from RAM.
        check_single_access(1'b0, 32'h0000_0304);
        check_value("o_rd_data", rdata, expected);
        expected = merge_bytes(ram_mem[12'h048], 32'h5555_AAAA, 4'b0011);
        clear_ram_log();
        cpu_access(1'b1, 32'h0000_0120, 4'b0011, 32'h5555_AAAA, rdata, stalls);
        check_single_access(1'b1, 32'h0000_0120);
        check_value("ram word", ram_mem[12'h048], expected);
        i_cache_en = 1'b1;
endtask

`endif

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

        localparam int RAM_WORDS      = 4096;           // 16 KB model RAM.
        localparam int STIM_DELAY     = 1;              // Drive after the rising edge.
        localparam int NUM_ACCESSES   = 16;             // CPU accesses over all tests.
        localparam int TIMEOUT_CYCLES = 20 * NUM_ACCESSES * 8;

        // ------------------------------
        // DUT signals.
        // ------------------------------
        logic        i_clk = 1'b0;
        logic        i_reset;
        logic        i_read_en;
        logic        i_write_en;
        logic [3:0]  i_ben;
        logic [31:0] i_wr_data;
        logic [31:0] i_address;
        logic [31:0] i_address_nxt;
        logic [31:0] o_rd_data;
        logic        o_stall;
        logic        i_cache_en;
        logic        i_cache_inv;
        logic        i_clear_from_writeback;
        logic [31:0] o_ram_address;
        logic [31:0] o_ram_wr_data;
        logic [3:0]  o_ram_ben;
        logic        o_ram_rd_en;
        logic        o_ram_wr_en;
        logic [31:0] i_ram_rd_data;
        logic        i_ram_done;

        // Model RAM and its access logs.
        logic [31:0] ram_mem [RAM_WORDS];
        logic [31:0] rd_log [$];                        // Read addresses, in order.
        logic [31:0] wr_log [$];
        logic [31:0] lcg_state = 32'd57;

        int          error_count = 0;
        int          check_count = 0;
        int          cycle_count = 0;

        dcache_top UUT (.*);

        always #50 i_clk = ~i_clk;                      // 100 ns period.

        // ------------------------------
        // Helpers.
        // ------------------------------
        function automatic logic [31:0] next_rand();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        // Initial RAM contents. Every address bit matters.
        function automatic logic [31:0] pattern_word(input logic [31:0] addr);
                return (addr * 32'h0100_0193) ^ {addr[15:0], ~addr[15:0]};
        endfunction

        function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                    input logic [31:0] new_word,
                                                    input logic [3:0]  ben);
                logic [31:0] result;
                result = old_word;
                for (int b = 0; b < 4; b++)
                begin
                        if (ben[b])
                                result[b*8 +: 8] = new_word[b*8 +: 8];  // Enabled lane only.
                end
                return result;
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
                check_count++;
                if (got !== expected)
                begin
                        error_count++;
                        $display("error at %0t: %s = %h, expected %h", $time, name, got, expected);
                end
        endtask

        // ------------------------------
        // RAM model.
        // ------------------------------
        initial
        begin : ram_model
                logic        cmd_rd;
                logic        cmd_wr;
                logic        finishing;
                logic        busy;
                logic [31:0] cmd_addr;
                logic [31:0] cmd_data;
                logic [3:0]  cmd_ben;
                int          wait_left;

                i_ram_done    = 1'b0;
                i_ram_rd_data = '0;
                busy          = 1'b0;
                wait_left     = 0;
                for (int i = 0; i < RAM_WORDS; i++)
                        ram_mem[i] = pattern_word(32'(i) << 2);

                forever
                begin
                        @(negedge i_clk);                       // Command is stable here.
                        cmd_rd    = o_ram_rd_en;
                        cmd_wr    = o_ram_wr_en;
                        cmd_addr  = o_ram_address;
                        cmd_data  = o_ram_wr_data;
                        cmd_ben   = o_ram_ben;
                        finishing = i_ram_done;
                        if (finishing)
                        begin
                                // Next rising edge completes the command.
                                if (cmd_wr)
                                begin
                                        ram_mem[cmd_addr[13:2]] =
                                                merge_bytes(ram_mem[cmd_addr[13:2]], cmd_data, cmd_ben);
                                        wr_log.push_back(cmd_addr);
                                end
                                if (cmd_rd)
                                        rd_log.push_back(cmd_addr);
                        end

                        @(posedge i_clk);
                        #STIM_DELAY;
                        if (finishing)
                        begin
                                i_ram_done = 1'b0;
                                busy       = 1'b0;
                        end
                        else if (cmd_rd || cmd_wr)
                        begin
                                if (!busy)
                                begin
                                        busy      = 1'b1;
                                        wait_left = int'((next_rand() >> 16) % 32'd4);  // 0..3.
                                end
                                if (wait_left == 0)
                                begin
                                        i_ram_done    = 1'b1;
                                        i_ram_rd_data = ram_mem[cmd_addr[13:2]];
                                end
                                else
                                        wait_left--;
                        end
                end
        end

        // Run limit.
        always @(posedge i_clk)
        begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES)
                begin
                        $display("Timeout: tests still running after %0d cycles", cycle_count);
                        $display("Test FAILED");
                        $finish;
                end
        end

        `include "dcache_tests.svh"

        // ------------------------------
        // Main sequence.
        // ------------------------------
        initial
        begin
                i_reset                = 1'b1;
                i_read_en              = 1'b0;
                i_write_en             = 1'b0;
                i_ben                  = 4'h0;
                i_wr_data              = '0;
                i_address              = '0;
                i_address_nxt          = '0;
                i_cache_en             = 1'b1;
                i_cache_inv            = 1'b0;
                i_clear_from_writeback = 1'b0;

                repeat (5) @(posedge i_clk);            // Reset for 5 cycles.
                #STIM_DELAY;
                i_reset = 1'b0;

                read_miss_fill();
                read_hit_all_words();
                write_through_merge();
                invalidate_and_refill();
                conflict_replacement();
                cache_disabled_passthrough();

                $display("Checks run: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0)
                        $display("Test OK");
                else
                        $display("Test FAILED");
                $finish;
        end

endmodule

//--- dcache_top.f
+incdir+verification
rtl/dcache_pkg.sv
rtl/line_fill_fsm.sv
rtl/line_store.sv
rtl/load_return.sv
rtl/dcache_top.sv
verification/dcache_tb.sv

//--- Makefile
VERILATOR = verilator
TOP       = dcache_tb
RTL_TOP   = dcache_top
FILELIST  = dcache_top.f
FLAGS     = --binary --timing
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
